//--- rv32_decode_consts.svh
`ifndef RV32_DECODE_CONSTS_SVH
`define RV32_DECODE_CONSTS_SVH

// ~~~~~~~~~~~~~~~~~~~~
// Packet shape
// ~~~~~~~~~~~~~~~~~~~~
`define RV_LANES 2  // Decode lanes per fetch packet.
`define RV_XLEN  32 // Instruction and pc width.

// ~~~~~~~~~~~~~~~~~~~~
// Field widths
// ~~~~~~~~~~~~~~~~~~~~
`define RV_REG_W 5  // Register index.
`define RV_OPC_W 5  // Opcode bits 6..2.
`define RV_OP_W  6  // Operation code.
`define RV_CSR_W 12 // CSR address.

`endif

//--- rv32_pkg.sv
`default_nettype none
`include "rv32_decode_consts.svh"

package rv32_pkg;

    // ~~~~~~~~~~~~~~~~~~~~
    // Opcode classes, instruction bits 6..2
    typedef enum logic [`RV_OPC_W-1:0] {
        OPC_LOAD   = 5'b00000,
        OPC_OP_IMM = 5'b00100,
        OPC_AUIPC  = 5'b00101,
        OPC_STORE  = 5'b01000,
        OPC_OP     = 5'b01100,
        OPC_LUI    = 5'b01101,
        OPC_BRANCH = 5'b11000,
        OPC_JALR   = 5'b11001,
        OPC_JAL    = 5'b11011,
        OPC_SYSTEM = 5'b11100
    } opclass_e;

    // ~~~~~~~~~~~~~~~~~~~~
    // Decoded operations
    typedef enum logic [`RV_OP_W-1:0] {
        OP_ILLEGAL,
        OP_LUI, OP_AUIPC, OP_JAL, OP_JALR,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
        OP_SB, OP_SH, OP_SW,
        OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI,
        OP_SLLI, OP_SRLI, OP_SRAI,
        OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
        OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND,
        OP_CSRRW, OP_CSRRS, OP_CSRRC,
        OP_CSRRWI, OP_CSRRSI, OP_CSRRCI,
        OP_ECALL, OP_EBREAK, OP_MRET, OP_SRET, OP_WFI
    } inst_op_e;

    typedef struct packed {
        logic                valid;
        logic [`RV_XLEN-1:0] pc;
        logic [`RV_XLEN-1:0] instr;
    } fetch_slot_t;

    typedef struct packed {
        logic                 valid;
        inst_op_e             op;
        logic                 illegal;
        logic [`RV_REG_W-1:0] rd;
        logic [`RV_REG_W-1:0] rs1;       // Also the CSR uimm.
        logic [`RV_REG_W-1:0] rs2;
        logic                 reads_rs1;
        logic                 reads_rs2;
        logic                 writes_rd; // Never set for x0.
        logic [`RV_XLEN-1:0]  imm;       // CSR address for Zicsr.
        logic [`RV_XLEN-1:0]  pc;
    } decoded_t;

endpackage

`default_nettype wire

//--- fetch_splitter.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv32_decode_consts.svh"

module fetch_splitter (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          fetch_valid,
    input  logic [`RV_XLEN-1:0]           fetch_pc,
    input  logic [`RV_LANES*`RV_XLEN-1:0] fetch_bundle,
    output rv32_pkg::fetch_slot_t         slots [`RV_LANES]
);

    // ~~~~~~~~~~~~~~~~~~~~
    // Slot registers
    // ~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        for (int i = 0; i < `RV_LANES; i++) begin
            slots[i].valid <= fetch_valid; // Drops on an idle cycle.
            if (fetch_valid) begin
                slots[i].pc    <= fetch_pc + `RV_XLEN'(4 * i);
                slots[i].instr <= fetch_bundle[i*`RV_XLEN +: `RV_XLEN];
            end
        end
        if (!rst_n) begin
            for (int i = 0; i < `RV_LANES; i++) begin
                slots[i].valid <= 1'b0;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Checks
    // ~~~~~~~~~~~~~~~~~~~~
    for (genvar g = 0; g < `RV_LANES; g++) begin : gen_align_chk
        a_pc_aligned: assert property (
            @(posedge clk) disable iff (!rst_n)
            (fetch_valid && fetch_pc[1:0] == 2'b00) |=> (slots[g].pc[1:0] == 2'b00)
        );
    end

endmodule

`default_nettype wire

//--- instruction_decoder.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv32_decode_consts.svh"

module instruction_decoder (
    input  logic                  clk,
    input  logic                  rst_n,
    input  rv32_pkg::fetch_slot_t slot,
    output rv32_pkg::decoded_t    dec
);

    logic [`RV_XLEN-1:0] instr;
    rv32_pkg::opclass_e  opclass;
    logic [2:0]          funct3;
    logic [6:0]          funct7;
    logic [`RV_XLEN-1:0] imm_i;
    logic [`RV_XLEN-1:0] imm_s;
    logic [`RV_XLEN-1:0] imm_b;
    logic [`RV_XLEN-1:0] imm_u;
    logic [`RV_XLEN-1:0] imm_j;
    logic [`RV_XLEN-1:0] imm_csr;
    rv32_pkg::inst_op_e  op_c;
    logic                use_rs1_c;
    logic                use_rs2_c;
    logic                use_rd_c;
    logic [`RV_XLEN-1:0] imm_c;

    assign instr   = slot.instr;
    assign opclass = rv32_pkg::opclass_e'(instr[6:2]);
    assign funct3  = instr[14:12];
    assign funct7  = instr[31:25];

    // ~~~~~~~~~~~~~~~~~~~~
    // Immediate formats
    // ~~~~~~~~~~~~~~~~~~~~
    assign imm_i   = {{20{instr[31]}}, instr[31:20]};
    assign imm_s   = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b   = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u   = {instr[31:12], 12'b0};
    assign imm_j   = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
    assign imm_csr = {{(`RV_XLEN-`RV_CSR_W){1'b0}}, instr[31:20]};

    // ~~~~~~~~~~~~~~~~~~~~
    // Operation select
    // ~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        op_c      = rv32_pkg::OP_ILLEGAL;
        use_rs1_c = 1'b0;
        use_rs2_c = 1'b0;
        use_rd_c  = 1'b0;
        imm_c     = '0;
        case (opclass)
            rv32_pkg::OPC_LUI: begin
                op_c     = rv32_pkg::OP_LUI;
                use_rd_c = 1'b1;
                imm_c    = imm_u;
            end
            rv32_pkg::OPC_AUIPC: begin
                op_c     = rv32_pkg::OP_AUIPC;
                use_rd_c = 1'b1;
                imm_c    = imm_u;
            end
            rv32_pkg::OPC_JAL: begin
                op_c     = rv32_pkg::OP_JAL;
                use_rd_c = 1'b1;
                imm_c    = imm_j;
            end
            rv32_pkg::OPC_JALR: begin
                if (funct3 == 3'b000) op_c = rv32_pkg::OP_JALR;
                use_rs1_c = 1'b1;
                use_rd_c  = 1'b1;
                imm_c     = imm_i;
            end
            rv32_pkg::OPC_BRANCH: begin
                case (funct3)
                    3'b000:  op_c = rv32_pkg::OP_BEQ;
                    3'b001:  op_c = rv32_pkg::OP_BNE;
                    3'b100:  op_c = rv32_pkg::OP_BLT;
                    3'b101:  op_c = rv32_pkg::OP_BGE;
                    3'b110:  op_c = rv32_pkg::OP_BLTU;
                    3'b111:  op_c = rv32_pkg::OP_BGEU;
                    default: op_c = rv32_pkg::OP_ILLEGAL;
                endcase
                use_rs1_c = 1'b1;
                use_rs2_c = 1'b1;
                imm_c     = imm_b;
            end
            rv32_pkg::OPC_LOAD: begin
                case (funct3)
                    3'b000:  op_c = rv32_pkg::OP_LB;
                    3'b001:  op_c = rv32_pkg::OP_LH;
                    3'b010:  op_c = rv32_pkg::OP_LW;
                    3'b100:  op_c = rv32_pkg::OP_LBU;
                    3'b101:  op_c = rv32_pkg::OP_LHU;
                    default: op_c = rv32_pkg::OP_ILLEGAL;
                endcase
                use_rs1_c = 1'b1;
                use_rd_c  = 1'b1;
                imm_c     = imm_i;
            end
            rv32_pkg::OPC_STORE: begin
                case (funct3)
                    3'b000:  op_c = rv32_pkg::OP_SB;
                    3'b001:  op_c = rv32_pkg::OP_SH;
                    3'b010:  op_c = rv32_pkg::OP_SW;
                    default: op_c = rv32_pkg::OP_ILLEGAL;
                endcase
                use_rs1_c = 1'b1;
                use_rs2_c = 1'b1;
                imm_c     = imm_s;
            end
            rv32_pkg::OPC_OP_IMM: begin
                case (funct3)
                    3'b000:  op_c = rv32_pkg::OP_ADDI;
                    3'b010:  op_c = rv32_pkg::OP_SLTI;
                    3'b011:  op_c = rv32_pkg::OP_SLTIU;
                    3'b100:  op_c = rv32_pkg::OP_XORI;
                    3'b110:  op_c = rv32_pkg::OP_ORI;
                    3'b111:  op_c = rv32_pkg::OP_ANDI;
                    3'b001: begin
                        if (funct7 == 7'h00) op_c = rv32_pkg::OP_SLLI;
                    end
                    default: begin // Right shifts.
                        if (funct7 == 7'h00) op_c = rv32_pkg::OP_SRLI;
                        else if (funct7 == 7'h20) op_c = rv32_pkg::OP_SRAI;
                    end
                endcase
                use_rs1_c = 1'b1;
                use_rd_c  = 1'b1;
                imm_c     = imm_i;
            end
            rv32_pkg::OPC_OP: begin
                case ({funct7, funct3})
                    {7'h00, 3'b000}: op_c = rv32_pkg::OP_ADD;
                    {7'h20, 3'b000}: op_c = rv32_pkg::OP_SUB;
                    {7'h00, 3'b001}: op_c = rv32_pkg::OP_SLL;
                    {7'h00, 3'b010}: op_c = rv32_pkg::OP_SLT;
                    {7'h00, 3'b011}: op_c = rv32_pkg::OP_SLTU;
                    {7'h00, 3'b100}: op_c = rv32_pkg::OP_XOR;
                    {7'h00, 3'b101}: op_c = rv32_pkg::OP_SRL;
                    {7'h20, 3'b101}: op_c = rv32_pkg::OP_SRA;
                    {7'h00, 3'b110}: op_c = rv32_pkg::OP_OR;
                    {7'h00, 3'b111}: op_c = rv32_pkg::OP_AND;
                    default:         op_c = rv32_pkg::OP_ILLEGAL;
                endcase
                use_rs1_c = 1'b1;
                use_rs2_c = 1'b1;
                use_rd_c  = 1'b1;
            end
            rv32_pkg::OPC_SYSTEM: begin
                if (funct3 == 3'b000) begin
                    case (instr) // Exact encodings only.
                        32'h0000_0073: op_c = rv32_pkg::OP_ECALL;
                        32'h0010_0073: op_c = rv32_pkg::OP_EBREAK;
                        32'h3020_0073: op_c = rv32_pkg::OP_MRET;
                        32'h1020_0073: op_c = rv32_pkg::OP_SRET;
                        32'h1050_0073: op_c = rv32_pkg::OP_WFI;
                        default:       op_c = rv32_pkg::OP_ILLEGAL;
                    endcase
                end else begin
                    case (funct3)
                        3'b001:  op_c = rv32_pkg::OP_CSRRW;
                        3'b010:  op_c = rv32_pkg::OP_CSRRS;
                        3'b011:  op_c = rv32_pkg::OP_CSRRC;
                        3'b101:  op_c = rv32_pkg::OP_CSRRWI;
                        3'b110:  op_c = rv32_pkg::OP_CSRRSI;
                        3'b111:  op_c = rv32_pkg::OP_CSRRCI;
                        default: op_c = rv32_pkg::OP_ILLEGAL;
                    endcase
                    use_rs1_c = !funct3[2]; // Immediate forms carry a uimm.
                    use_rd_c  = 1'b1;
                    imm_c     = imm_csr;
                end
            end
            default: op_c = rv32_pkg::OP_ILLEGAL;
        endcase
        // Only 32-bit encodings, so bits 1..0 must be 11.
        if (instr[1:0] != 2'b11) op_c = rv32_pkg::OP_ILLEGAL;
        if (op_c == rv32_pkg::OP_ILLEGAL) begin
            use_rs1_c = 1'b0;
            use_rs2_c = 1'b0;
            use_rd_c  = 1'b0;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Output register
    // ~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        dec.valid     <= slot.valid;
        dec.op        <= op_c;
        dec.illegal   <= (op_c == rv32_pkg::OP_ILLEGAL);
        dec.rd        <= instr[11:7];
        dec.rs1       <= instr[19:15];
        dec.rs2       <= instr[24:20];
        dec.reads_rs1 <= use_rs1_c;
        dec.reads_rs2 <= use_rs2_c;
        dec.writes_rd <= use_rd_c && (instr[11:7] != '0);
        dec.imm       <= imm_c;
        dec.pc        <= slot.pc;
        if (!rst_n) dec.valid <= 1'b0;
    end

    a_dec_consistent: assert property (
        @(posedge clk) disable iff (!rst_n)
        dec.valid |-> (dec.illegal == (dec.op == rv32_pkg::OP_ILLEGAL))
                      && (!dec.writes_rd || dec.rd != '0)
    );

endmodule

`default_nettype wire

//--- issue_collector.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv32_decode_consts.svh"

module issue_collector (
    input  logic                 clk,
    input  logic                 rst_n,
    input  rv32_pkg::decoded_t   decs [`RV_LANES],
    output logic                 issue_valid,
    output logic [`RV_LANES-1:0] issue_mask,
    output rv32_pkg::decoded_t   issue_insts [`RV_LANES],
    output logic                 trap_valid,
    output logic [`RV_XLEN-1:0]  trap_pc,
    output logic                 replay_valid,
    output logic [`RV_XLEN-1:0]  replay_pc
);

    logic [`RV_LANES-1:0] hazard_c;
    logic [`RV_LANES-1:0] mask_c;
    logic                 trap_c;
    logic                 replay_c;
    logic [`RV_XLEN-1:0]  block_pc_c;

    // ~~~~~~~~~~~~~~~~~~~~
    // Intra-packet RAW hazards
    // ~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        hazard_c = '0;
        for (int i = 1; i < `RV_LANES; i++) begin
            for (int j = 0; j < i; j++) begin
                if (decs[j].writes_rd &&
                    ((decs[i].reads_rs1 && decs[i].rs1 == decs[j].rd) ||
                     (decs[i].reads_rs2 && decs[i].rs2 == decs[j].rd))) begin
                    hazard_c[i] = 1'b1;
                end
            end
        end
    end

    // Issue stops at the first blocked lane.
    always_comb begin : blk_issue
        logic lane_open;
        lane_open  = 1'b1;
        mask_c     = '0;
        trap_c     = 1'b0;
        replay_c   = 1'b0;
        block_pc_c = '0;
        for (int i = 0; i < `RV_LANES; i++) begin
            if (!decs[i].valid) begin
                lane_open = 1'b0;
            end else if (lane_open && !decs[i].illegal && !hazard_c[i]) begin
                mask_c[i] = 1'b1;
            end else if (lane_open) begin
                lane_open  = 1'b0;
                trap_c     = decs[i].illegal;
                replay_c   = !decs[i].illegal;
                block_pc_c = decs[i].pc;
            end
        end
    end

    always_ff @(posedge clk) begin
        issue_valid  <= decs[0].valid;
        issue_mask   <= mask_c;
        issue_insts  <= decs;
        trap_valid   <= trap_c;
        trap_pc      <= block_pc_c;
        replay_valid <= replay_c;
        replay_pc    <= block_pc_c;
        if (!rst_n) begin
            issue_valid  <= 1'b0;
            issue_mask   <= '0;
            trap_valid   <= 1'b0;
            replay_valid <= 1'b0;
            for (int i = 0; i < `RV_LANES; i++) begin
                issue_insts[i].valid <= 1'b0;
            end
        end
    end

    a_mask_no_gap: assert property (
        @(posedge clk) disable iff (!rst_n)
        (issue_mask & (issue_mask + 1'b1)) == '0
    );

    for (genvar g = 0; g < `RV_LANES; g++) begin : gen_mask_chk
        a_mask_valid: assert property (
            @(posedge clk) disable iff (!rst_n)
            issue_mask[g] |-> issue_insts[g].valid
        );
    end

endmodule

`default_nettype wire

//--- decode_stage.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv32_decode_consts.svh"

module decode_stage (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          fetch_valid,
    input  logic [`RV_XLEN-1:0]           fetch_pc,
    input  logic [`RV_LANES*`RV_XLEN-1:0] fetch_bundle,
    output logic                          issue_valid,
    output logic [`RV_LANES-1:0]          issue_mask,
    output rv32_pkg::decoded_t            issue_insts [`RV_LANES],
    output logic                          trap_valid,
    output logic [`RV_XLEN-1:0]           trap_pc,
    output logic                          replay_valid,
    output logic [`RV_XLEN-1:0]           replay_pc
);

    rv32_pkg::fetch_slot_t slots [`RV_LANES];
    rv32_pkg::decoded_t    decs  [`RV_LANES];

    fetch_splitter u_splitter (
        .clk          (clk),
        .rst_n        (rst_n),
        .fetch_valid  (fetch_valid),
        .fetch_pc     (fetch_pc),
        .fetch_bundle (fetch_bundle),
        .slots        (slots)
    );

    // ~~~~~~~~~~~~~~~~~~~~
    // One decoder per lane.
    for (genvar g = 0; g < `RV_LANES; g++) begin : gen_lane
        instruction_decoder u_decoder (
            .clk   (clk),
            .rst_n (rst_n),
            .slot  (slots[g]),
            .dec   (decs[g])
        );
    end

    issue_collector u_collector (
        .clk          (clk),
        .rst_n        (rst_n),
        .decs         (decs),
        .issue_valid  (issue_valid),
        .issue_mask   (issue_mask),
        .issue_insts  (issue_insts),
        .trap_valid   (trap_valid),
        .trap_pc      (trap_pc),
        .replay_valid (replay_valid),
        .replay_pc    (replay_pc)
    );

endmodule

`default_nettype wire

//--- tb_decode_stage.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv32_decode_consts.svh"

module tb_decode_stage;

    localparam logic [6:0] opc_load   = 7'h03;
    localparam logic [6:0] opc_imm    = 7'h13;
    localparam logic [6:0] opc_store  = 7'h23;
    localparam logic [6:0] opc_op     = 7'h33;
    localparam logic [6:0] opc_lui    = 7'h37;
    localparam logic [6:0] opc_branch = 7'h63;
    localparam logic [6:0] opc_jal    = 7'h6F;
    localparam logic [6:0] opc_system = 7'h73;

    logic                          clk = 1'b0;
    logic                          rst_n;
    logic                          fetch_valid;
    logic [`RV_XLEN-1:0]           fetch_pc;
    logic [`RV_LANES*`RV_XLEN-1:0] fetch_bundle;
    logic                          issue_valid;
    logic [`RV_LANES-1:0]          issue_mask;
    rv32_pkg::decoded_t            issue_insts [`RV_LANES];
    logic                          trap_valid;
    logic [`RV_XLEN-1:0]           trap_pc;
    logic                          replay_valid;
    logic [`RV_XLEN-1:0]           replay_pc;
    int                            seed;
    int                            cyc = 0;
    int                            entry_q [$]; // Cycle in which each packet was offered.

    decode_stage DUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .fetch_valid  (fetch_valid),
        .fetch_pc     (fetch_pc),
        .fetch_bundle (fetch_bundle),
        .issue_valid  (issue_valid),
        .issue_mask   (issue_mask),
        .issue_insts  (issue_insts),
        .trap_valid   (trap_valid),
        .trap_pc      (trap_pc),
        .replay_valid (replay_valid),
        .replay_pc    (replay_pc)
    );

    always #10 clk = ~clk;
    always @(posedge clk) cyc <= cyc + 1;
    always @(negedge clk) if (fetch_valid) entry_q.push_back(cyc);

    // ~~~~~~~~~~~~~~~~~~~~
    // Encoders
    // ~~~~~~~~~~~~~~~~~~~~
    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [6:0] opc);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], opc};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [6:0] opc);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc};
    endfunction

    function automatic logic [31:0] enc_u(input logic [31:0] imm, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm[31:12], rd, opc};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc};
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~
    // Checking and driving
    // ~~~~~~~~~~~~~~~~~~~~
    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("Mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp));
        end
    endtask

    task automatic drive_packet(input logic [31:0] pc, input logic [31:0] w0,
                                input logic [31:0] w1);
        @(posedge clk);
        fetch_valid  <= 1'b1;
        fetch_pc     <= pc;
        fetch_bundle <= (`RV_LANES*`RV_XLEN)'({w1, w0});
    endtask

    task automatic drive_idle();
        @(posedge clk);
        fetch_valid <= 1'b0;
    endtask

    // Returns at the falling edge where issue_valid is high.
    task automatic wait_issue();
        int n;
        int entry;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (!issue_valid) check("issue_mask", 32'(issue_mask), 32'd0);
        end while (!issue_valid && n < 10);
        if (!issue_valid) fail_run("Timed out waiting for issue_valid.");
        if (entry_q.size() == 0) fail_run("issue_valid pulsed with no packet sent.");
        entry = entry_q.pop_front();
        check("latency", 32'(cyc - entry), 32'd3);
        check("trap_and_replay", 32'(trap_valid && replay_valid), 32'd0);
    endtask

    task automatic run_packet(input logic [31:0] pc, input logic [31:0] w0,
                              input logic [31:0] w1);
        drive_packet(pc, w0, w1);
        drive_idle();
        wait_issue();
    endtask

    task automatic check_outcome(input logic [`RV_LANES-1:0] mask, input logic trap,
                                 input logic replay, input logic [31:0] block_pc);
        check("issue_mask", 32'(issue_mask), 32'(mask));
        check("trap_valid", 32'(trap_valid), 32'(trap));
        check("replay_valid", 32'(replay_valid), 32'(replay));
        if (trap) check("trap_pc", trap_pc, block_pc);
        if (replay) check("replay_pc", replay_pc, block_pc);
    endtask

    // uses is {reads_rs1, reads_rs2, writes_rd}.
    task automatic check_lane(input int lane, input logic [31:0] word,
                              input rv32_pkg::inst_op_e op, input logic [2:0] uses,
                              input logic [31:0] imm, input logic [31:0] pc);
        rv32_pkg::decoded_t d;
        d = issue_insts[lane];
        check($sformatf("lane%0d.valid", lane), 32'(d.valid), 32'd1);
        check($sformatf("lane%0d.op", lane), 32'(d.op), 32'(op));
        check($sformatf("lane%0d.illegal", lane), 32'(d.illegal), 32'd0);
        check($sformatf("lane%0d.rd", lane), 32'(d.rd), 32'(word[11:7]));
        check($sformatf("lane%0d.rs1", lane), 32'(d.rs1), 32'(word[19:15]));
        check($sformatf("lane%0d.rs2", lane), 32'(d.rs2), 32'(word[24:20]));
        check($sformatf("lane%0d.uses", lane),
              32'({d.reads_rs1, d.reads_rs2, d.writes_rd}), 32'(uses));
        check($sformatf("lane%0d.imm", lane), d.imm, imm);
        check($sformatf("lane%0d.pc", lane), d.pc, pc);
    endtask

    task automatic format_pair(input logic [31:0] pc,
                               input logic [31:0] w0, input rv32_pkg::inst_op_e op0,
                               input logic [2:0] u0, input logic [31:0] i0,
                               input logic [31:0] w1, input rv32_pkg::inst_op_e op1,
                               input logic [2:0] u1, input logic [31:0] i1);
        run_packet(pc, w0, w1);
        check_outcome(2'b11, 1'b0, 1'b0, 32'd0);
        check_lane(0, w0, op0, u0, i0, pc);
        check_lane(1, w1, op1, u1, i1, pc + 32'd4);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // Tests
    // ~~~~~~~~~~~~~~~~~~~~
    task automatic test_idle();
        repeat (10) begin
            @(negedge clk);
            check("issue_valid", 32'(issue_valid), 32'd0);
            check("trap_valid", 32'(trap_valid), 32'd0);
            check("replay_valid", 32'(replay_valid), 32'd0);
            check("issue_mask", 32'(issue_mask), 32'd0);
        end
    endtask

    task automatic test_formats();
        format_pair(32'h1000, enc_r(7'h00, 7, 6, 3'b000, 5, opc_op), rv32_pkg::OP_ADD,
                    3'b111, 32'd0,
                    enc_r(7'h20, 10, 9, 3'b000, 8, opc_op), rv32_pkg::OP_SUB,
                    3'b111, 32'd0);
        format_pair(32'h1008, enc_i(12'hFFB, 12, 3'b000, 11, opc_imm), rv32_pkg::OP_ADDI,
                    3'b101, 32'hFFFF_FFFB,
                    enc_i({7'h20, 5'd3}, 14, 3'b101, 13, opc_imm), rv32_pkg::OP_SRAI,
                    3'b101, 32'h0000_0403);
        format_pair(32'h1010, enc_i(12'hFF0, 16, 3'b010, 15, opc_load), rv32_pkg::OP_LW,
                    3'b101, 32'hFFFF_FFF0,
                    enc_s(12'h7FC, 17, 18, 3'b010, opc_store), rv32_pkg::OP_SW,
                    3'b110, 32'h0000_07FC);
        format_pair(32'h1018, enc_b(13'h1FF8, 20, 19, 3'b001, opc_branch), rv32_pkg::OP_BNE,
                    3'b110, 32'hFFFF_FFF8,
                    enc_u(32'hABCD_E000, 21, opc_lui), rv32_pkg::OP_LUI,
                    3'b001, 32'hABCD_E000);
        format_pair(32'h1020, enc_j(21'h1F_F800, 1, opc_jal), rv32_pkg::OP_JAL,
                    3'b001, 32'hFFFF_F800,
                    enc_i(12'h300, 5, 3'b110, 22, opc_system), rv32_pkg::OP_CSRRSI,
                    3'b001, 32'h0000_0300);
        format_pair(32'h1028, 32'h0000_0073, rv32_pkg::OP_ECALL, 3'b000, 32'd0,
                    enc_i(12'h000, 0, 3'b000, 0, opc_imm), rv32_pkg::OP_ADDI,
                    3'b100, 32'd0); // Nop writes x0, so no rd use.
    endtask

    task automatic test_illegal();
        logic [31:0] good;
        logic [31:0] bad [4];
        good   = enc_i(12'h001, 2, 3'b000, 1, opc_imm);
        bad[0] = enc_r(7'h00, 3, 2, 3'b000, 4, opc_op) ^ 32'h1; // Low bits 10.
        bad[1] = enc_b(13'h0008, 2, 3, 3'b010, opc_branch);
        bad[2] = enc_r(7'h01, 3, 2, 3'b000, 4, opc_op);
        bad[3] = 32'h0;
        for (int k = 0; k < 4; k++) begin
            run_packet(32'h3000 + 32'(k) * 32'd8, good, bad[k]);
            check_outcome(2'b01, 1'b1, 1'b0, 32'h3004 + 32'(k) * 32'd8);
            check("lane1.op", 32'(issue_insts[1].op), 32'(rv32_pkg::OP_ILLEGAL));
            check("lane1.illegal", 32'(issue_insts[1].illegal), 32'd1);
            check("lane1.uses", 32'({issue_insts[1].reads_rs1, issue_insts[1].reads_rs2,
                                     issue_insts[1].writes_rd}), 32'd0);
        end
        run_packet(32'h3100, 32'h0, good);
        check_outcome(2'b00, 1'b1, 1'b0, 32'h3100);
    endtask

    task automatic test_hazards();
        logic [31:0] wr_x5;
        wr_x5 = enc_i(12'h001, 1, 3'b000, 5, opc_imm);
        run_packet(32'h3200, wr_x5, enc_r(7'h00, 2, 5, 3'b000, 6, opc_op));
        check_outcome(2'b01, 1'b0, 1'b1, 32'h3204);
        run_packet(32'h3208, wr_x5, enc_s(12'h000, 5, 3, 3'b010, opc_store)); // Via rs2.
        check_outcome(2'b01, 1'b0, 1'b1, 32'h320C);
        run_packet(32'h3210, enc_i(12'h001, 1, 3'b000, 0, opc_imm),
                   enc_r(7'h00, 0, 0, 3'b000, 6, opc_op));
        check_outcome(2'b11, 1'b0, 1'b0, 32'd0);
        run_packet(32'h3218, wr_x5, enc_r(7'h00, 8, 7, 3'b000, 6, opc_op));
        check_outcome(2'b11, 1'b0, 1'b0, 32'd0);
    endtask

    task automatic test_back_to_back();
        for (int k = 0; k < 3; k++) begin
            drive_packet(32'h5000 + 32'(k) * 32'd8, enc_i(12'(k), 1, 3'b000, 5'(k + 10), opc_imm),
                         enc_r(7'h00, 3, 2, 3'b000, 4, opc_op));
        end
        drive_idle();
        for (int k = 0; k < 3; k++) begin
            wait_issue();
            check_outcome(2'b11, 1'b0, 1'b0, 32'd0);
            check("lane0.pc", issue_insts[0].pc, 32'h5000 + 32'(k) * 32'd8);
            check("lane1.pc", issue_insts[1].pc, 32'h5004 + 32'(k) * 32'd8);
        end
        @(negedge clk);
        check("issue_valid", 32'(issue_valid), 32'd0);
    endtask

    task automatic test_random();
        logic [31:0] r;
        logic [31:0] pc;
        logic [31:0] w1;
        logic        use_add;
        logic        hazard;
        for (int k = 0; k < 20; k++) begin
            r       = $random(seed);
            use_add = r[25];
            pc      = 32'h6000 + 32'(k) * 32'd8;
            w1 = use_add ? enc_r(7'h00, r[24:20], r[19:15], 3'b000, r[14:10], opc_op)
                         : enc_i(12'(k), r[19:15], 3'b000, r[14:10], opc_imm);
            // Lane 1 waits if it reads the nonzero rd of lane 0.
            hazard = (r[4:0] != 5'd0) &&
                     (r[19:15] == r[4:0] || (use_add && r[24:20] == r[4:0]));
            run_packet(pc, enc_i(12'h001, r[9:5], 3'b000, r[4:0], opc_imm), w1);
            check_outcome(hazard ? 2'b01 : 2'b11, 1'b0, hazard, pc + 32'd4);
        end
    endtask

    initial begin
        seed         = 32'h4802bb48;
        rst_n        = 1'b0;
        fetch_valid  = 1'b0;
        fetch_pc     = '0;
        fetch_bundle = '0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        test_idle();
        test_formats();
        test_illegal();
        test_hazards();
        test_back_to_back();
        test_random();
        repeat (2) @(posedge clk);
        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
+incdir+.
rv32_pkg.sv
fetch_splitter.sv
instruction_decoder.sv
issue_collector.sv
decode_stage.sv
tb_decode_stage.sv

//--- Makefile
TOP = tb_decode_stage

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f src.f --top-module decode_stage
	verilator --lint-only --timing -f src.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "^Done: no errors$$" sim.log

clean:
	rm -rf obj_dir sim.log
